//--- include/barrel_settings.svh
`ifndef BARREL_SETTINGS_SVH
`define BARREL_SETTINGS_SVH

// Thread count is 2**BARREL_THREAD_BITS and must cover the pipeline depth
`define BARREL_THREAD_BITS      3
`define BARREL_PC_WIDTH         8

`define BARREL_INSTR_WIDTH      32
`define BARREL_IMM_WIDTH        16
`define BARREL_DATA_WIDTH       64
`define BARREL_REG_INDEX_BITS   5
`define BARREL_DMEM_ADDR_BITS   8

// Instruction fields
`define BARREL_OPCODE_MSB       31
`define BARREL_OPCODE_LSB       28
`define BARREL_REG_MSB          20
`define BARREL_REG_LSB          16

// Opcodes, anything else is a no-op
`define BARREL_OP_INCREMENT     4'd1
`define BARREL_OP_LOAD          4'd2
`define BARREL_OP_STORE         4'd3

`endif

//--- logic/barrel_pkg.sv
`include "barrel_settings.svh"

package barrel_pkg;

    typedef logic [`BARREL_THREAD_BITS-1:0]    thread_t;
    typedef logic [`BARREL_PC_WIDTH-1:0]       pc_t;
    typedef logic [`BARREL_INSTR_WIDTH-1:0]    instr_t;
    typedef logic [`BARREL_REG_INDEX_BITS-1:0] reg_index_t;
    typedef logic [`BARREL_IMM_WIDTH-1:0]      imm_t;
    typedef logic [`BARREL_DATA_WIDTH-1:0]     data_t;
    typedef logic [`BARREL_DMEM_ADDR_BITS-1:0] dmem_offset_t;

    // Every memory is split per thread by the top address bits
    typedef struct packed {
        thread_t thread;
        pc_t     pc;
    } imem_addr_t;

    typedef struct packed {
        thread_t    thread;
        reg_index_t reg_index;
    } reg_addr_t;

    typedef struct packed {
        thread_t      thread;
        dmem_offset_t offset;
    } dmem_addr_t;

    typedef struct packed {
        logic increment;
        logic load_word;
        logic store_word;
    } op_flags_t;

    typedef struct packed {
        op_flags_t  flags;
        reg_index_t reg_index;
        imm_t       imm;
        thread_t    thread;
    } decode_ex_t;

    typedef struct packed {
        op_flags_t  flags;
        reg_index_t reg_index;
        imm_t       imm;
        thread_t    thread;
        data_t      data;
    } ex_mem_t;

    typedef struct packed {
        logic       write_back;
        reg_index_t reg_index;
        thread_t    thread;
        data_t      data;
    } mem_wb_t;

endpackage

//--- logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t d,
    output payload_t q
);

    // All-zero payload means no flags set, so the stage does nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

//--- logic/thread_scheduler.sv
`timescale 1ns/1ps

module thread_scheduler
    import barrel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output imem_addr_t fetch_addr
);

    localparam int THREAD_COUNT = 2 ** $bits(thread_t);

    thread_t thread;
    pc_t     pc_table [THREAD_COUNT];

    assign fetch_addr = '{thread: thread, pc: pc_table[thread]};

    // One fetch per cycle, threads taken in strict rotation
    always_ff @(posedge clk) begin
        if (reset) begin
            thread <= '0;
            for (int i = 0; i < THREAD_COUNT; i++) begin
                pc_table[i] <= '0;
            end
        end else begin
            thread           <= thread + 1'b1;
            pc_table[thread] <= pc_table[thread] + 1'b1;
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

`include "barrel_settings.svh"

module decode_stage
    import barrel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  imem_addr_t fetch_addr,
    input  instr_t     instruction,
    input  mem_wb_t    writeback,
    output reg_addr_t  reg_access_raddr,
    output reg_addr_t  reg_access_waddr,
    output data_t      reg_access_wdata,
    output logic       reg_access_we,
    output decode_ex_t decoded
);

    localparam int OPCODE_WIDTH = `BARREL_OPCODE_MSB - `BARREL_OPCODE_LSB + 1;

    instr_t                  instr_q;
    thread_t                 thread_q;
    logic                    valid_q;
    logic [OPCODE_WIDTH-1:0] opcode;

    // Fetch/decode boundary
    always_ff @(posedge clk) begin
        instr_q  <= instruction;
        thread_q <= fetch_addr.thread;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    assign opcode = instr_q[`BARREL_OPCODE_MSB:`BARREL_OPCODE_LSB];

    always_comb begin
        decoded.flags = '0;
        if (valid_q) begin
            case (opcode)
                `BARREL_OP_INCREMENT: decoded.flags.increment  = 1'b1;
                `BARREL_OP_LOAD:      decoded.flags.load_word  = 1'b1;
                `BARREL_OP_STORE:     decoded.flags.store_word = 1'b1;
                default: ;
            endcase
        end
        decoded.reg_index = instr_q[`BARREL_REG_MSB:`BARREL_REG_LSB];
        decoded.imm       = instr_q[`BARREL_IMM_WIDTH-1:0];
        decoded.thread    = thread_q;
    end

    // Read data comes back in the operand cycle
    assign reg_access_raddr = '{thread: thread_q, reg_index: decoded.reg_index};

    // Writeback shares the register file port set with decode
    assign reg_access_waddr = '{thread: writeback.thread, reg_index: writeback.reg_index};
    assign reg_access_wdata = writeback.data;
    assign reg_access_we    = writeback.write_back;

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import barrel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  decode_ex_t operands,
    input  data_t      reg_access_rdata,
    output ex_mem_t    result
);

    ex_mem_t captured_d;
    ex_mem_t captured_q;

    // Operand cycle joins decoded fields with register read data
    assign captured_d = '{
        flags:     operands.flags,
        reg_index: operands.reg_index,
        imm:       operands.imm,
        thread:    operands.thread,
        data:      reg_access_rdata
    };

    pipe_reg #(
        .payload_t(ex_mem_t)
    ) operand_reg (
        .clk   (clk),
        .reset (reset),
        .d     (captured_d),
        .q     (captured_q)
    );

    // Immediate is unsigned, zero extended to the data width
    always_comb begin
        result = captured_q;
        if (captured_q.flags.increment) begin
            result.data = captured_q.data + data_t'(captured_q.imm);
        end
    end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
    import barrel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  ex_mem_t    access,
    input  data_t      data_mem_rdata,
    output dmem_addr_t data_mem_raddr,
    output dmem_addr_t data_mem_waddr,
    output data_t      data_mem_wdata,
    output logic       data_mem_we,
    output mem_wb_t    completion
);

    typedef struct packed {
        logic    load_word;
        mem_wb_t wb;
    } mem2_t;

    dmem_addr_t mem_addr;
    mem2_t      mem2_d;
    mem2_t      mem2_q;

    // Low immediate bits give the offset inside the thread's window
    assign mem_addr = '{thread: access.thread, offset: dmem_offset_t'(access.imm)};

    // Read is issued for every instruction, only loads use the result
    assign data_mem_raddr = mem_addr;
    assign data_mem_waddr = mem_addr;
    assign data_mem_wdata = access.data;
    assign data_mem_we    = access.flags.store_word;

    assign mem2_d = '{
        load_word: access.flags.load_word,
        wb: '{
            write_back: access.flags.increment | access.flags.load_word,
            reg_index:  access.reg_index,
            thread:     access.thread,
            data:       access.data
        }
    };

    pipe_reg #(
        .payload_t(mem2_t)
    ) mem1_mem2_reg (
        .clk   (clk),
        .reset (reset),
        .d     (mem2_d),
        .q     (mem2_q)
    );

    // Memory read data lands in mem2
    always_comb begin
        completion = mem2_q.wb;
        if (mem2_q.load_word) begin
            completion.data = data_mem_rdata;
        end
    end

endmodule

//--- logic/barrel_core.sv
`timescale 1ns/1ps

module barrel_core
    import barrel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    output imem_addr_t instr_mem_pc,
    input  instr_t     instr_mem_instruction,

    output reg_addr_t  reg_access_raddr,
    input  data_t      reg_access_rdata,
    output reg_addr_t  reg_access_waddr,
    output data_t      reg_access_wdata,
    output logic       reg_access_we,

    output dmem_addr_t data_mem_raddr,
    input  data_t      data_mem_rdata,
    output dmem_addr_t data_mem_waddr,
    output data_t      data_mem_wdata,
    output logic       data_mem_we
);

    decode_ex_t decoded;
    decode_ex_t operands;
    ex_mem_t    executed;
    ex_mem_t    access;
    mem_wb_t    completion;
    mem_wb_t    writeback;

    thread_scheduler scheduler (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (instr_mem_pc)
    );

    decode_stage decode (
        .clk              (clk),
        .reset            (reset),
        .fetch_addr       (instr_mem_pc),
        .instruction      (instr_mem_instruction),
        .writeback        (writeback),
        .reg_access_raddr (reg_access_raddr),
        .reg_access_waddr (reg_access_waddr),
        .reg_access_wdata (reg_access_wdata),
        .reg_access_we    (reg_access_we),
        .decoded          (decoded)
    );

    pipe_reg #(.payload_t(decode_ex_t)) decode_operand_reg (
        .clk   (clk),
        .reset (reset),
        .d     (decoded),
        .q     (operands)
    );

    execute_stage execute (
        .clk              (clk),
        .reset            (reset),
        .operands         (operands),
        .reg_access_rdata (reg_access_rdata),
        .result           (executed)
    );

    pipe_reg #(.payload_t(ex_mem_t)) execute_mem1_reg (
        .clk   (clk),
        .reset (reset),
        .d     (executed),
        .q     (access)
    );

    memory_stage memory (
        .clk            (clk),
        .reset          (reset),
        .access         (access),
        .data_mem_rdata (data_mem_rdata),
        .data_mem_raddr (data_mem_raddr),
        .data_mem_waddr (data_mem_waddr),
        .data_mem_wdata (data_mem_wdata),
        .data_mem_we    (data_mem_we),
        .completion     (completion)
    );

    // Writeback register feeds the register file write port in decode
    pipe_reg #(.payload_t(mem_wb_t)) mem2_writeback_reg (
        .clk   (clk),
        .reset (reset),
        .d     (completion),
        .q     (writeback)
    );

endmodule

//--- test/barrel_tb.sv
`timescale 1ns/1ps

`include "barrel_settings.svh"

module barrel_tb
    import barrel_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int THREADS    = 2 ** `BARREL_THREAD_BITS;
    localparam int PC_SPAN    = 2 ** `BARREL_PC_WIDTH;
    localparam int REG_SPAN   = 2 ** `BARREL_REG_INDEX_BITS;
    localparam int DMEM_SPAN  = 2 ** `BARREL_DMEM_ADDR_BITS;
    localparam int IMEM_WORDS = THREADS * PC_SPAN;
    localparam int REG_WORDS  = THREADS * REG_SPAN;
    localparam int DMEM_WORDS = THREADS * DMEM_SPAN;

    // Run lengths in cycles, whole thread rounds
    localparam int SCHEDULE_CYCLES  = 24;
    localparam int CHAIN_CYCLES     = 48;
    localparam int STORE_CYCLES     = 16;
    localparam int LOAD_INC_CYCLES  = 24;
    localparam int ISOLATION_CYCLES = 56;
    localparam int RESET_OVERHEAD   = 4;
    localparam int TOTAL_CYCLES     = SCHEDULE_CYCLES + CHAIN_CYCLES + STORE_CYCLES
        + LOAD_INC_CYCLES + ISOLATION_CYCLES + 5 * RESET_OVERHEAD;
    localparam int WATCHDOG_NS      = 2 * TOTAL_CYCLES * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       load_images = 1'b0;
    imem_addr_t instr_mem_pc;
    instr_t     instr_mem_instruction;
    reg_addr_t  reg_access_raddr;
    data_t      reg_access_rdata = '0;
    reg_addr_t  reg_access_waddr;
    data_t      reg_access_wdata;
    logic       reg_access_we;
    dmem_addr_t data_mem_raddr;
    data_t      data_mem_rdata = '0;
    dmem_addr_t data_mem_waddr;
    data_t      data_mem_wdata;
    logic       data_mem_we;

    instr_t imem [IMEM_WORDS];
    data_t  regs [REG_WORDS];
    data_t  dmem [DMEM_WORDS];
    data_t  reg_image [REG_WORDS];
    data_t  dmem_image [DMEM_WORDS];

    int     error_count = 0;
    int     check_count = 0;
    integer seed;

    barrel_core dut0 (
        .clk                   (clk),
        .reset                 (reset),
        .instr_mem_pc          (instr_mem_pc),
        .instr_mem_instruction (instr_mem_instruction),
        .reg_access_raddr      (reg_access_raddr),
        .reg_access_rdata      (reg_access_rdata),
        .reg_access_waddr      (reg_access_waddr),
        .reg_access_wdata      (reg_access_wdata),
        .reg_access_we         (reg_access_we),
        .data_mem_raddr        (data_mem_raddr),
        .data_mem_rdata        (data_mem_rdata),
        .data_mem_waddr        (data_mem_waddr),
        .data_mem_wdata        (data_mem_wdata),
        .data_mem_we           (data_mem_we)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign instr_mem_instruction = imem[instr_mem_pc];

    // Register file and data memory, synchronous read and write
    always @(posedge clk) begin
        if (reg_access_we) begin
            regs[reg_access_waddr] <= reg_access_wdata;
        end
        if (data_mem_we) begin
            dmem[data_mem_waddr] <= data_mem_wdata;
        end
        // Fresh contents for the next test, taken during reset
        if (load_images) begin
            for (int i = 0; i < REG_WORDS; i++) begin
                regs[i] <= reg_image[i];
            end
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= dmem_image[i];
            end
        end
        reg_access_rdata <= regs[reg_access_raddr];
        data_mem_rdata   <= dmem[data_mem_raddr];
    end

    function automatic int imem_slot(int thread, int pc);
        return thread * PC_SPAN + pc;
    endfunction

    function automatic int reg_slot(int thread, int reg_num);
        return thread * REG_SPAN + reg_num;
    endfunction

    function automatic int dmem_slot(int thread, int offset);
        return thread * DMEM_SPAN + offset;
    endfunction

    // Low halves sit close to overflow so increments carry upward
    function automatic data_t reg_fill(int index);
        return {32'hc0de_0000 | 32'(index), 32'hffff_ff00 | 32'(index)};
    endfunction

    function automatic data_t dmem_fill(int index);
        return {32'hda7a_0000 | 32'(index), 32'hfff0_0000 | 32'(index)};
    endfunction

    function automatic instr_t encode(logic [3:0] opcode, int reg_num, int imm);
        instr_t word;
        word = '0;
        word[`BARREL_OPCODE_MSB:`BARREL_OPCODE_LSB] = opcode;
        word[`BARREL_REG_MSB:`BARREL_REG_LSB]       = reg_index_t'(reg_num);
        word[`BARREL_IMM_WIDTH-1:0]                 = imm_t'(imm);
        return word;
    endfunction

    // Opcode fetched in cycle k after reset by the round-robin rule
    function automatic logic [3:0] fetched_opcode(int cycle);
        instr_t word;
        word = imem[imem_slot(cycle % THREADS, (cycle / THREADS) % PC_SPAN)];
        return word[`BARREL_OPCODE_MSB:`BARREL_OPCODE_LSB];
    endfunction

    task automatic check(string name, data_t actual, data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Opcode 0 everywhere, so the whole instruction memory is no-ops
    task automatic load_default_images();
        int i;
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = encode(4'h0, 0, i);
        end
        for (i = 0; i < REG_WORDS; i++) begin
            reg_image[i] = reg_fill(i);
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem_image[i] = dmem_fill(i);
        end
    endtask

    // Returns at the edge that starts cycle 0
    task automatic apply_reset();
        @(posedge clk);
        reset       <= 1'b1;
        load_images <= 1'b1;
        @(posedge clk);
        load_images <= 1'b0;
        @(negedge clk);
        check("reg_access_we", data_t'(reg_access_we), '0);
        check("data_mem_we", data_t'(data_mem_we), '0);
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic run_cycles(int cycles);
        repeat (cycles) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic schedule_after_reset();
        int   k;
        int   t;
        logic exp_store;
        logic exp_write;
        load_default_images();
        for (t = 0; t < THREADS; t++) begin
            imem[imem_slot(t, 0)] = encode(`BARREL_OP_STORE, t, 'h40);
            imem[imem_slot(t, 1)] = encode(`BARREL_OP_INCREMENT, 1, 1);
        end
        apply_reset();
        for (k = 0; k < SCHEDULE_CYCLES; k++) begin
            @(negedge clk);
            exp_store = (k >= 4) && (fetched_opcode(k - 4) == `BARREL_OP_STORE);
            exp_write = (k >= 6) && ((fetched_opcode(k - 6) == `BARREL_OP_INCREMENT)
                || (fetched_opcode(k - 6) == `BARREL_OP_LOAD));
            check("instr_mem_pc", data_t'(instr_mem_pc),
                data_t'((k % THREADS) * PC_SPAN + (k / THREADS) % PC_SPAN));
            check("data_mem_we", data_t'(data_mem_we), data_t'(exp_store));
            check("reg_access_we", data_t'(reg_access_we), data_t'(exp_write));
        end
    endtask

    task automatic increment_chain();
        int    i;
        imm_t  imm;
        data_t expected;
        load_default_images();
        expected = reg_fill(reg_slot(3, 7));
        for (i = 0; i < 5; i++) begin
            imm                   = imm_t'($random(seed));
            expected              = expected + data_t'(imm);
            imem[imem_slot(3, i)] = encode(`BARREL_OP_INCREMENT, 7, int'(imm));
        end
        apply_reset();
        run_cycles(CHAIN_CYCLES);
        check("regs[3][7]", regs[reg_slot(3, 7)], expected);
        check("regs[3][6]", regs[reg_slot(3, 6)], reg_fill(reg_slot(3, 6)));
        check("regs[2][7]", regs[reg_slot(2, 7)], reg_fill(reg_slot(2, 7)));
    endtask

    task automatic store_per_thread();
        int t;
        load_default_images();
        for (t = 0; t < THREADS; t++) begin
            imem[imem_slot(t, 0)] = encode(`BARREL_OP_STORE, t + 2, 'h10);
        end
        apply_reset();
        run_cycles(STORE_CYCLES);
        for (t = 0; t < THREADS; t++) begin
            check($sformatf("dmem[%0d][10]", t), dmem[dmem_slot(t, 'h10)],
                reg_fill(reg_slot(t, t + 2)));
            check($sformatf("dmem[%0d][0f]", t), dmem[dmem_slot(t, 'h0f)],
                dmem_fill(dmem_slot(t, 'h0f)));
            check($sformatf("dmem[%0d][11]", t), dmem[dmem_slot(t, 'h11)],
                dmem_fill(dmem_slot(t, 'h11)));
        end
    endtask

    task automatic load_then_increment();
        load_default_images();
        imem[imem_slot(5, 0)] = encode(`BARREL_OP_LOAD, 9, 'h22);
        imem[imem_slot(5, 1)] = encode(`BARREL_OP_INCREMENT, 9, 'h1234);
        apply_reset();
        run_cycles(LOAD_INC_CYCLES);
        check("regs[5][9]", regs[reg_slot(5, 9)], dmem_fill(dmem_slot(5, 'h22)) + 64'h1234);
        check("dmem[5][22]", dmem[dmem_slot(5, 'h22)], dmem_fill(dmem_slot(5, 'h22)));
        check("regs[4][9]", regs[reg_slot(4, 9)], reg_fill(reg_slot(4, 9)));
    endtask

    // Same program on every thread, unknown opcodes 7 and f
    task automatic noop_isolation();
        int    t;
        data_t sum;
        load_default_images();
        for (t = 0; t < THREADS; t++) begin
            imem[imem_slot(t, 0)] = encode(`BARREL_OP_INCREMENT, 1, 'h0100);
            imem[imem_slot(t, 1)] = encode(4'hf, 2, 'h0055);
            imem[imem_slot(t, 2)] = encode(`BARREL_OP_STORE, 1, 'h20);
            imem[imem_slot(t, 3)] = encode(`BARREL_OP_LOAD, 3, 'h30);
            imem[imem_slot(t, 4)] = encode(`BARREL_OP_INCREMENT, 3, 'h0003);
            imem[imem_slot(t, 5)] = encode(4'h7, 4, 'h0020);
        end
        apply_reset();
        run_cycles(ISOLATION_CYCLES);
        for (t = 0; t < THREADS; t++) begin
            sum = reg_fill(reg_slot(t, 1)) + 64'h100;
            check($sformatf("regs[%0d][1]", t), regs[reg_slot(t, 1)], sum);
            check($sformatf("regs[%0d][2]", t), regs[reg_slot(t, 2)], reg_fill(reg_slot(t, 2)));
            check($sformatf("regs[%0d][3]", t), regs[reg_slot(t, 3)],
                dmem_fill(dmem_slot(t, 'h30)) + 64'h3);
            check($sformatf("regs[%0d][4]", t), regs[reg_slot(t, 4)], reg_fill(reg_slot(t, 4)));
            check($sformatf("dmem[%0d][20]", t), dmem[dmem_slot(t, 'h20)], sum);
            check($sformatf("dmem[%0d][30]", t), dmem[dmem_slot(t, 'h30)],
                dmem_fill(dmem_slot(t, 'h30)));
            check($sformatf("dmem[%0d][55]", t), dmem[dmem_slot(t, 'h55)],
                dmem_fill(dmem_slot(t, 'h55)));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests were still running after %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed = 32'hc550_65c1;
        schedule_after_reset();
        increment_chain();
        store_per_thread();
        load_then_increment();
        noop_isolation();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
logic/barrel_pkg.sv
logic/pipe_reg.sv
logic/thread_scheduler.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/barrel_core.sv
test/barrel_tb.sv

//--- Makefile
TOP := barrel_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
